/* predictor.f */
source/bp_config_pkg.sv
source/bp_types_pkg.sv
source/kind_table.sv
source/history_tables.sv
source/direction_predictor.sv
source/target_predictor.sv
source/predictor.sv
testbench/tb_clock.sv
testbench/predictor_assertions.sv
testbench/predictor_tb.sv

/* Bender.yml */
package:
  name: predictor

sources:
  - source/bp_config_pkg.sv
  - source/bp_types_pkg.sv
  - source/kind_table.sv
  - source/history_tables.sv
  - source/direction_predictor.sv
  - source/target_predictor.sv
  - source/predictor.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/predictor_assertions.sv
      - testbench/predictor_tb.sv

/* testbench/predictor_tb.sv */
`timescale 1ns/1ps

module predictor_tb;

    localparam int aw = bp_config_pkg::addr_width;
    localparam int bw = bp_config_pkg::bh_width;
    localparam int depth = bp_config_pkg::table_depth;
    // reset, cold, train, ras, direction, stall
    localparam int timeout_cycles = 4 * (8 + 16 + 120 + 53 + 120 + 80);

    logic clk, rstn, stall, update_en, taken_real, taken_pdc;
    logic [aw-1:0] pc, pc_ex, npc_ex, ret_pc_ex, npc_pdc;
    logic [bw-1:0] bh_ex, bh_pdc;
    logic [1:0] pdch_ex, pdch;
    bp_types_pkg::kind_t kind_ex, kind_pdc;

    // reference model
    bp_types_pkg::kind_t kind_m [depth];
    logic [bw-1:0] bh_m [depth];
    logic [1:0]    loc_m [depth];
    logic [1:0]    gsh_m [depth];
    logic [1:0]    ch_m [depth];
    logic          btb_v [depth];
    logic [7:0]    btb_tag_m [depth];
    logic [aw-1:0] btb_tgt_m [depth];
    logic [aw-1:0] ras_q [$];
    logic [5:0]    gh_m;

    logic [aw-1:0] pool [16];   // 16 indices with distinct tags
    bp_types_pkg::kind_t exp_kind;
    logic          exp_taken;
    logic [aw-1:0] exp_npc;
    logic [bw-1:0] exp_bh;
    logic [1:0]    exp_pdch;
    logic [31:0]   held [5];
    integer        seed;
    int            cycle_count = 0;

    tb_clock clock_inst (.clk(clk));

    predictor predictor_inst (.*);

    bind predictor predictor_assertions predictor_assertions_inst (.*);

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        if (up && c != 2'd3) return c + 2'd1;
        if (!up && c != 2'd0) return c - 2'd1;
        return c;
    endfunction

    function automatic logic [aw-1:0] rand_pc(input int base, input int span);
        return pool[base + $unsigned($random(seed)) % span];
    endfunction

    function automatic void predict(input logic [aw-1:0] p);
        logic [5:0] idx;
        logic       dir;
        idx      = p[5:0];
        exp_kind = kind_m[idx];
        exp_bh   = bh_m[idx];
        exp_pdch = {gsh_m[gh_m ^ idx][1], loc_m[bh_m[idx][5:0] ^ idx][1]};
        dir      = ch_m[idx][1] ? exp_pdch[1] : exp_pdch[0];   // upper half picks gshare
        case (exp_kind)
            bp_types_pkg::not_jump:    exp_taken = 1'b0;
            bp_types_pkg::direct_jump: exp_taken = dir;
            default:                   exp_taken = 1'b1;
        endcase
        exp_npc = p + 1'b1;
        if (exp_taken && exp_kind == bp_types_pkg::ret) begin
            if (ras_q.size() > 0) exp_npc = ras_q[$];
        end else if (exp_taken && btb_v[idx] && btb_tag_m[idx] == p[13:6]) begin
            exp_npc = btb_tgt_m[idx];
        end
    endfunction

    // exp_bh and exp_pdch hold the lookup-time values of p
    function automatic void model_update(input logic [aw-1:0] p, input bp_types_pkg::kind_t k,
                                         input logic t, input logic [aw-1:0] tgt);
        logic [5:0] idx;
        idx = p[5:0];
        kind_m[idx] = k;
        if (k == bp_types_pkg::direct_jump) begin
            loc_m[exp_bh[5:0] ^ idx] = sat_step(loc_m[exp_bh[5:0] ^ idx], t);
            gsh_m[gh_m ^ idx] = sat_step(gsh_m[gh_m ^ idx], t);
            if (exp_pdch[1] != exp_pdch[0]) ch_m[idx] = sat_step(ch_m[idx], exp_pdch[1] == t);
        end
        if (k != bp_types_pkg::not_jump) begin
            bh_m[idx] = {bh_m[idx][bw-2:0], t};
            gh_m = {gh_m[4:0], t};
        end
        if (t && k != bp_types_pkg::not_jump && k != bp_types_pkg::ret) begin
            btb_v[idx]     = 1'b1;
            btb_tag_m[idx] = p[13:6];
            btb_tgt_m[idx] = tgt;
        end
        if (k == bp_types_pkg::call) begin
            ras_q.push_back(p + 1'b1);
            if (ras_q.size() > bp_config_pkg::ras_depth) ras_q.pop_front();   // oldest lost
        end else if (k == bp_types_pkg::ret && ras_q.size() > 0) begin
            ras_q.pop_back();
        end
    endfunction

    task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("error %s: expected %h, actual %h", name, exp_v, act_v);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic lookup(input string name, input logic [aw-1:0] p);
        predict(p);
        pc        = p;
        stall     = 1'b0;
        update_en = 1'b0;
        @(negedge clk);
        check({name, " kind"}, 32'(exp_kind), 32'(kind_pdc));
        check({name, " taken"}, 32'(exp_taken), 32'(taken_pdc));
        check({name, " npc"}, 32'(exp_npc), 32'(npc_pdc));
        check({name, " bh"}, 32'(exp_bh), 32'(bh_pdc));
        check({name, " pdch"}, 32'(exp_pdch), 32'(pdch));
        held[0] = 32'(exp_kind);
        held[1] = 32'(exp_taken);
        held[2] = 32'(exp_npc);
        held[3] = 32'(exp_bh);
        held[4] = 32'(exp_pdch);
    endtask

    task automatic commit(input logic [aw-1:0] p, input bp_types_pkg::kind_t k, input logic t,
                          input logic [aw-1:0] tgt, input logic hold);
        predict(p);
        stall      = hold;
        update_en  = 1'b1;
        pc_ex      = p;
        kind_ex    = k;
        taken_real = t;
        npc_ex     = t ? tgt : p + 1'b1;
        ret_pc_ex  = p + 1'b1;
        bh_ex      = exp_bh;
        pdch_ex    = exp_pdch;
        model_update(p, k, t, npc_ex);
        @(negedge clk);
    endtask

    task automatic check_held();
        check("stall kind", held[0], 32'(kind_pdc));
        check("stall taken", held[1], 32'(taken_pdc));
        check("stall npc", held[2], 32'(npc_pdc));
        check("stall bh", held[3], 32'(bh_pdc));
        check("stall pdch", held[4], 32'(pdch));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("CHECKS FAILED");
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [aw-1:0] p;
        bp_types_pkg::kind_t k;
        int span;
        seed       = 32'h46f3;
        rstn       = 1'b0;
        stall      = 1'b0;
        update_en  = 1'b0;
        taken_real = 1'b0;
        pc         = '0;
        pc_ex      = '0;
        npc_ex     = '0;
        ret_pc_ex  = '0;
        kind_ex    = bp_types_pkg::not_jump;
        bh_ex      = '0;
        pdch_ex    = '0;
        gh_m       = '0;
        for (int i = 0; i < depth; i++) begin
            kind_m[i] = bp_types_pkg::not_jump;
            bh_m[i]   = '0;
            loc_m[i]  = 2'd1;
            gsh_m[i]  = 2'd1;
            ch_m[i]   = 2'd1;   // weak_local
            btb_v[i]  = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            pool[i] = {16'($random(seed)), 8'(i * 13 + 7), 6'(i * 4 + ($random(seed) & 3))};
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < 16; i++) lookup("cold", rand_pc(0, 16));

        for (int i = 0; i < 40; i++) begin
            case ($unsigned($random(seed)) % 3)
                0: k = bp_types_pkg::jump;
                1: k = bp_types_pkg::call;
                default: k = bp_types_pkg::indirect_jump;
            endcase
            commit(rand_pc(0, 16), k, 1'b1, 30'($random(seed)), 1'b0);
            lookup("train", rand_pc(0, 16));
            p = rand_pc(0, 16);
            lookup("tag miss", {p[aw-1:14], p[13:6] ^ 8'h80, p[5:0]});
        end

        // pool[0] becomes the ret site and calls come from the rest
        commit(pool[0], bp_types_pkg::ret, 1'b1, 30'($random(seed)), 1'b0);
        for (int i = 0; i < 12; i++) begin
            commit(rand_pc(1, 15), bp_types_pkg::call, 1'b1, 30'($random(seed)), 1'b0);
            lookup("ras push", pool[0]);
        end
        for (int i = 0; i < 14; i++) begin
            commit(pool[0], bp_types_pkg::ret, 1'b1, 30'($random(seed)), 1'b0);
            lookup("ras pop", pool[0]);
        end

        for (int i = 0; i < 60; i++) begin
            commit(rand_pc(4, 4), bp_types_pkg::direct_jump, 1'($random(seed)), pool[12], 1'b0);
            lookup("direction", rand_pc(4, 4));
        end

        for (int i = 0; i < 10; i++) begin
            lookup("pre stall", rand_pc(0, 16));
            span = 1 + $unsigned($random(seed)) % 6;
            repeat (span) begin
                if ($random(seed) & 1) begin
                    commit(rand_pc(4, 4), bp_types_pkg::direct_jump, 1'($random(seed)),
                           pool[13], 1'b1);
                end else begin
                    stall     = 1'b1;
                    update_en = 1'b0;
                    pc        = rand_pc(0, 16);
                    @(negedge clk);
                end
                check_held();
            end
        end
        lookup("after stall", rand_pc(0, 16));

        if (predictor_inst.predictor_assertions_inst.fail_count != 0) begin
            $display("CHECKS FAILED");
            $display("%0d concurrent assertion failures were reported",
                     predictor_inst.predictor_assertions_inst.fail_count);
            $fatal(1, "assertion failures");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* testbench/predictor_assertions.sv */
`timescale 1ns/1ps

module predictor_assertions (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  bp_types_pkg::kind_t                   kind_pdc,
    input  logic                                  taken_pdc,
    input  logic [bp_config_pkg::addr_width-1:0]  npc_pdc,
    input  logic [bp_config_pkg::bh_width-1:0]    bh_pdc,
    input  logic [1:0]                            pdch
);

    int fail_count = 0;   // failure tally

    kind_legal: assert property (@(posedge clk) disable iff (!rstn)
        kind_pdc inside {bp_types_pkg::not_jump, bp_types_pkg::direct_jump, bp_types_pkg::ret,
                         bp_types_pkg::indirect_jump, bp_types_pkg::call, bp_types_pkg::jump})
    else begin
        fail_count++;
        $error("kind_pdc holds a value outside the kind enum");
    end

    // lookup pipeline frozen by stall
    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable({npc_pdc, kind_pdc, taken_pdc, bh_pdc, pdch}))
    else begin
        fail_count++;
        $error("predictor outputs changed across a stalled cycle");
    end

    not_jump_untaken: assert property (@(posedge clk) disable iff (!rstn)
        (kind_pdc == bp_types_pkg::not_jump) |-> !taken_pdc)
    else begin
        fail_count++;
        $error("taken_pdc set for a not_jump lookup");
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period_ns / 2) clk = ~clk;

endmodule

/* source/predictor.sv */
`timescale 1ns/1ps

module predictor (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  logic                                  update_en,
    input  logic                                  taken_real,
    input  logic [bp_config_pkg::addr_width-1:0]  pc,
    input  logic [bp_config_pkg::addr_width-1:0]  pc_ex,
    input  logic [bp_config_pkg::addr_width-1:0]  npc_ex,
    input  logic [bp_config_pkg::addr_width-1:0]  ret_pc_ex,
    input  bp_types_pkg::kind_t                   kind_ex,
    input  logic [bp_config_pkg::bh_width-1:0]    bh_ex,
    input  logic [1:0]                            pdch_ex,
    output logic [bp_config_pkg::addr_width-1:0]  npc_pdc,
    output bp_types_pkg::kind_t                   kind_pdc,
    output logic                                  taken_pdc,
    output logic [bp_config_pkg::bh_width-1:0]    bh_pdc,
    output logic [1:0]                            pdch
);

    logic [bp_config_pkg::addr_width-1:0] pc_reg, pc_seq, btb_target, ras_top;
    logic [bp_config_pkg::bh_width-1:0]   bh_rd;
    logic [bp_config_pkg::gh_width-1:0]   gh;
    logic                                 dir_taken, btb_hit, ras_valid;

    always_ff @(posedge clk) begin
        if (!rstn) pc_reg <= bp_config_pkg::reset_pc;
        else if (!stall) pc_reg <= pc;
    end

    assign pc_seq = pc_reg + 1'b1;
    assign bh_pdc = bh_rd;

    // next pc selection
    always_comb begin
        case (kind_pdc)
            bp_types_pkg::not_jump:    taken_pdc = 1'b0;
            bp_types_pkg::direct_jump: taken_pdc = dir_taken;
            default:                   taken_pdc = 1'b1;
        endcase
        if (!taken_pdc) npc_pdc = pc_seq;
        else if (kind_pdc == bp_types_pkg::ret) npc_pdc = ras_valid ? ras_top : pc_seq;
        else npc_pdc = btb_hit ? btb_target : pc_seq;
    end

    kind_table kind_table_inst (
        .clk(clk), .rstn(rstn), .stall(stall), .update_en(update_en),
        .pc(pc), .pc_ex(pc_ex), .kind_ex(kind_ex), .kind_pdc(kind_pdc)
    );

    history_tables history_tables_inst (
        .clk(clk), .rstn(rstn), .stall(stall), .update_en(update_en),
        .taken_real(taken_real), .pc(pc), .pc_ex(pc_ex), .kind_ex(kind_ex),
        .bh_rd(bh_rd), .gh(gh)
    );

    direction_predictor direction_predictor_inst (
        .clk(clk), .rstn(rstn), .stall(stall), .update_en(update_en),
        .taken_real(taken_real), .pc(pc), .pc_ex(pc_ex), .bh_rd(bh_rd), .gh(gh),
        .bh_ex(bh_ex), .pdch_ex(pdch_ex), .kind_ex(kind_ex),
        .dir_taken(dir_taken), .pdch(pdch)
    );

    target_predictor target_predictor_inst (
        .clk(clk), .rstn(rstn), .stall(stall), .update_en(update_en),
        .taken_real(taken_real), .pc(pc), .pc_ex(pc_ex), .npc_ex(npc_ex),
        .ret_pc_ex(ret_pc_ex), .kind_ex(kind_ex), .btb_hit(btb_hit),
        .ras_valid(ras_valid), .btb_target(btb_target), .ras_top(ras_top)
    );

endmodule

/* source/target_predictor.sv */
`timescale 1ns/1ps

module target_predictor (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  logic                                  update_en,
    input  logic                                  taken_real,
    input  logic [bp_config_pkg::addr_width-1:0]  pc,
    input  logic [bp_config_pkg::addr_width-1:0]  pc_ex,
    input  logic [bp_config_pkg::addr_width-1:0]  npc_ex,
    input  logic [bp_config_pkg::addr_width-1:0]  ret_pc_ex,
    input  bp_types_pkg::kind_t                   kind_ex,
    output logic                                  btb_hit,
    output logic                                  ras_valid,
    output logic [bp_config_pkg::addr_width-1:0]  btb_target,
    output logic [bp_config_pkg::addr_width-1:0]  ras_top
);

    logic                                 btb_valid [bp_config_pkg::table_depth];
    logic [bp_config_pkg::tag_width-1:0]  btb_tag   [bp_config_pkg::table_depth];
    logic [bp_config_pkg::addr_width-1:0] btb_tgt   [bp_config_pkg::table_depth];
    logic [bp_config_pkg::addr_width-1:0] ras_mem   [bp_config_pkg::ras_depth];

    logic [bp_config_pkg::index_width-1:0] rd_idx, wr_idx;
    logic [bp_config_pkg::tag_width-1:0]   pc_tag, pc_tag_q, tag_q;
    logic                                  valid_q, btb_wr, push, pop;
    logic [bp_config_pkg::ras_ptr_width-1:0] ras_ptr, top_idx;
    logic [bp_config_pkg::ras_ptr_width:0]   ras_cnt;

    assign rd_idx  = pc[bp_config_pkg::index_width-1:0];
    assign wr_idx  = pc_ex[bp_config_pkg::index_width-1:0];
    assign pc_tag  = pc[bp_config_pkg::index_width +: bp_config_pkg::tag_width];
    assign btb_hit = valid_q && (tag_q == pc_tag_q);
    assign btb_wr  = update_en && taken_real && (kind_ex != bp_types_pkg::not_jump) &&
                     (kind_ex != bp_types_pkg::ret);
    assign push    = update_en && (kind_ex == bp_types_pkg::call);
    assign pop     = update_en && (kind_ex == bp_types_pkg::ret);
    assign top_idx = ras_ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_config_pkg::table_depth; i++) begin
                btb_valid[i] <= 1'b0;
            end
            valid_q <= 1'b0;
        end else begin
            if (!stall) begin
                valid_q    <= btb_valid[rd_idx];
                tag_q      <= btb_tag[rd_idx];
                btb_target <= btb_tgt[rd_idx];
                pc_tag_q   <= pc_tag;
            end
            if (btb_wr) begin
                btb_valid[wr_idx] <= 1'b1;
                btb_tag[wr_idx]   <= pc_ex[bp_config_pkg::index_width +: bp_config_pkg::tag_width];
                btb_tgt[wr_idx]   <= npc_ex;
            end
        end
    end

    // circular stack, a push when full drops the oldest
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ras_ptr   <= '0;
            ras_cnt   <= '0;
            ras_valid <= 1'b0;
        end else begin
            if (!stall) begin
                ras_valid <= (ras_cnt != '0);   // sampled before this edge's update
                ras_top   <= ras_mem[top_idx];
            end
            if (push) begin
                ras_mem[ras_ptr] <= ret_pc_ex;
                ras_ptr          <= ras_ptr + 1'b1;
                if (ras_cnt != bp_config_pkg::ras_depth) ras_cnt <= ras_cnt + 1'b1;
            end else if (pop && ras_cnt != '0) begin
                ras_ptr <= top_idx;
                ras_cnt <= ras_cnt - 1'b1;
            end
        end
    end

endmodule

/* source/direction_predictor.sv */
`timescale 1ns/1ps

module direction_predictor (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  logic                                  update_en,
    input  logic                                  taken_real,
    input  logic [bp_config_pkg::addr_width-1:0]  pc,
    input  logic [bp_config_pkg::addr_width-1:0]  pc_ex,
    input  logic [bp_config_pkg::bh_width-1:0]    bh_rd,
    input  logic [bp_config_pkg::gh_width-1:0]    gh,
    input  logic [bp_config_pkg::bh_width-1:0]    bh_ex,
    input  logic [1:0]                            pdch_ex,
    input  bp_types_pkg::kind_t                   kind_ex,
    output logic                                  dir_taken,
    output logic [1:0]                            pdch
);

    logic [1:0]            local_tbl  [bp_config_pkg::table_depth];
    logic [1:0]            gshare_tbl [bp_config_pkg::table_depth];
    bp_types_pkg::choice_t choice_tbl [bp_config_pkg::table_depth];

    logic [bp_config_pkg::index_width-1:0] pc_idx, pc_ex_idx, pc_idx_q;
    logic [bp_config_pkg::index_width-1:0] l_rd_idx, l_wr_idx, g_rd_idx, g_wr_idx;
    logic [bp_config_pkg::index_width-1:0] pend_idx;
    logic [1:0]            gshare_q, pend_val, l_cur;
    bp_types_pkg::choice_t choice_q;
    logic                  pend_valid, stall_q, local_hold;
    logic                  local_taken, gshare_taken, update_dir;

    // 2-bit saturating counter step
    function automatic logic [1:0] next_cnt(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        end
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    assign pc_idx     = pc[bp_config_pkg::index_width-1:0];
    assign pc_ex_idx  = pc_ex[bp_config_pkg::index_width-1:0];
    assign l_rd_idx   = bh_rd[bp_config_pkg::index_width-1:0] ^ pc_idx_q;
    assign l_wr_idx   = bh_ex[bp_config_pkg::index_width-1:0] ^ pc_ex_idx;
    assign g_rd_idx   = gh ^ pc_idx;
    assign g_wr_idx   = gh ^ pc_ex_idx;
    assign update_dir = update_en && (kind_ex == bp_types_pkg::direct_jump);

    // local index needs bh_rd, so this read happens after the lookup edge.
    // writes land one edge late and the result is frozen under stall
    assign l_cur = (pend_valid && pend_idx == l_wr_idx) ? pend_val : local_tbl[l_wr_idx];
    assign local_taken  = stall_q ? local_hold : local_tbl[l_rd_idx][1];
    assign gshare_taken = gshare_q[1];

    assign pdch      = {gshare_taken, local_taken};
    assign dir_taken = (choice_q == bp_types_pkg::weak_global ||
                        choice_q == bp_types_pkg::strong_global) ? gshare_taken : local_taken;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_config_pkg::table_depth; i++) begin
                local_tbl[i] <= 2'b01;              // weakly not taken
            end
            pend_valid <= 1'b0;
            stall_q    <= 1'b0;
            local_hold <= 1'b0;
        end else begin
            stall_q    <= stall;
            local_hold <= local_taken;
            pend_valid <= update_dir;
            if (update_dir) begin
                pend_idx <= l_wr_idx;
                pend_val <= next_cnt(l_cur, taken_real);
            end
            if (pend_valid) local_tbl[pend_idx] <= pend_val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_config_pkg::table_depth; i++) begin
                gshare_tbl[i] <= 2'b01;
                choice_tbl[i] <= bp_types_pkg::weak_local;
            end
            pc_idx_q <= '0;
            gshare_q <= 2'b01;
            choice_q <= bp_types_pkg::weak_local;
        end else begin
            if (!stall) begin
                pc_idx_q <= pc_idx;
                gshare_q <= gshare_tbl[g_rd_idx];
                choice_q <= choice_tbl[pc_idx];
            end
            if (update_dir) begin
                gshare_tbl[g_wr_idx] <= next_cnt(gshare_tbl[g_wr_idx], taken_real);
                if (pdch_ex[1] != pdch_ex[0]) begin  // toward whichever was right
                    choice_tbl[pc_ex_idx] <= bp_types_pkg::choice_t'(
                        next_cnt(choice_tbl[pc_ex_idx], pdch_ex[1] == taken_real));
                end
            end
        end
    end

endmodule

/* source/history_tables.sv */
`timescale 1ns/1ps

module history_tables (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  logic                                  update_en,
    input  logic                                  taken_real,
    input  logic [bp_config_pkg::addr_width-1:0]  pc,
    input  logic [bp_config_pkg::addr_width-1:0]  pc_ex,
    input  bp_types_pkg::kind_t                   kind_ex,
    output logic [bp_config_pkg::bh_width-1:0]    bh_rd,
    output logic [bp_config_pkg::gh_width-1:0]    gh
);

    // per-pc local history
    logic [bp_config_pkg::bh_width-1:0] bht [bp_config_pkg::table_depth];

    logic [bp_config_pkg::index_width-1:0] rd_idx;
    logic [bp_config_pkg::index_width-1:0] wr_idx;
    logic                                  shift_en;

    assign rd_idx   = pc[bp_config_pkg::index_width-1:0];
    assign wr_idx   = pc_ex[bp_config_pkg::index_width-1:0];
    assign shift_en = update_en && (kind_ex != bp_types_pkg::not_jump);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_config_pkg::table_depth; i++) begin
                bht[i] <= '0;
            end
            bh_rd <= '0;
        end else begin
            if (!stall) begin
                bh_rd <= bht[rd_idx];
            end
            if (shift_en) begin
                bht[wr_idx] <= {bht[wr_idx][bp_config_pkg::bh_width-2:0], taken_real};
            end
        end
    end

    // global history, committed outcomes only
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else if (shift_en) begin
            gh <= {gh[bp_config_pkg::gh_width-2:0], taken_real};
        end
    end

endmodule

/* source/kind_table.sv */
`timescale 1ns/1ps

module kind_table (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  logic                                  update_en,
    input  logic [bp_config_pkg::addr_width-1:0]  pc,
    input  logic [bp_config_pkg::addr_width-1:0]  pc_ex,
    input  bp_types_pkg::kind_t                   kind_ex,
    output bp_types_pkg::kind_t                   kind_pdc
);

    bp_types_pkg::kind_t kind_mem [bp_config_pkg::table_depth];

    logic [bp_config_pkg::index_width-1:0] rd_idx;
    logic [bp_config_pkg::index_width-1:0] wr_idx;

    assign rd_idx = pc[bp_config_pkg::index_width-1:0];
    assign wr_idx = pc_ex[bp_config_pkg::index_width-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_config_pkg::table_depth; i++) begin
                kind_mem[i] <= bp_types_pkg::not_jump;
            end
            kind_pdc <= bp_types_pkg::not_jump;
        end else begin
            if (!stall) begin
                kind_pdc <= kind_mem[rd_idx];   // old value on a same-edge write
            end
            if (update_en) begin
                kind_mem[wr_idx] <= kind_ex;
            end
        end
    end

endmodule

/* source/bp_types_pkg.sv */
package bp_types_pkg;

    // instruction kind as seen by the predictor
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } kind_t;

    // chooser counter, low half picks local
    typedef enum logic [1:0] {
        strong_local, weak_local, weak_global, strong_global
    } choice_t;

endpackage

/* source/bp_config_pkg.sv */
package bp_config_pkg;

    // word address of a fetch pc
    localparam int addr_width = 30;

    // every table is indexed by pc[5:0]
    localparam int index_width = 6;
    localparam int table_depth = 1 << index_width;

    localparam int tag_width = 8;     // btb tag, pc[13:6]

    localparam int bh_width = 8;      // local history length
    localparam int gh_width = 6;      // global history length

    // return stack
    localparam int ras_depth = 8;
    localparam int ras_ptr_width = 3;

    localparam logic [addr_width-1:0] reset_pc = 30'h0700_0000;

endpackage
